//--- common/ooo_pkg.sv
package ooo_pkg;

	////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////

	// integer data width
	localparam int XLEN = 32;

	// one data word on the bus, in the ROB and in the register file
	typedef logic [XLEN-1:0] xlen_t;

	// raw 32-bit RISC-V instruction word
	typedef logic [31:0] inst_t;

	// architectural register index, x0 to x31
	typedef logic [4:0] reg_idx_t;

	////////////////////////////////////////
	// reorder buffer sizing
	////////////////////////////////////////

	// tag width sets the ROB size
	localparam int ROB_TAG_W = 3;
	localparam int ROB_DEPTH = 1 << ROB_TAG_W;

	// ROB slot number, also the rename tag on the bus
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////

	// one code per integer operation
	// immediate forms share these codes
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// major opcodes that are decoded
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

endpackage

//--- src/issue_control.sv
module issue_control (
	input  logic           clock,
	input  logic           reset,
	input  logic           inst_valid,
	input  ooo_pkg::inst_t inst,
	input  logic           rob_full,
	input  logic           rs_full,
	output logic           issue_stall,
	output logic           alloc_en,
	output ooo_pkg::inst_t issue_inst
);

	// issue register occupied
	logic issue_valid;

	// allocate when something waits and both queues have room
	assign alloc_en = issue_valid && !rob_full && !rs_full;

	// held instruction could not leave, so the input must wait
	assign issue_stall = issue_valid && !alloc_en;

	// valid bit, refilled when empty or when the held one leaves
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else if (!issue_valid || alloc_en) begin
			issue_valid <= inst_valid;
		end
	end

	// instruction word follows the same load condition
	always_ff @(posedge clock) begin
		if (!issue_valid || alloc_en) begin
			issue_inst <= inst;
		end
	end

endmodule

//--- src/issue_stage.sv
module issue_stage (
	input  logic               clock,
	input  logic               reset,
	input  ooo_pkg::inst_t     issue_inst,
	input  logic               commit_valid,
	input  logic               commit_wr_en,
	input  ooo_pkg::reg_idx_t  commit_idx,
	input  ooo_pkg::xlen_t     commit_data,
	input  logic               rs1_busy,
	input  ooo_pkg::rob_tag_t  rs1_tag,
	input  logic               rs2_busy,
	input  ooo_pkg::rob_tag_t  rs2_tag,
	input  logic               rob_rs1_ready,
	input  ooo_pkg::xlen_t     rob_rs1_value,
	input  logic               rob_rs2_ready,
	input  ooo_pkg::xlen_t     rob_rs2_value,
	output ooo_pkg::reg_idx_t  dest_idx,
	output logic               has_dest,
	output ooo_pkg::alu_op_e   alu_op,
	output ooo_pkg::xlen_t     op1,
	output ooo_pkg::xlen_t     op2,
	output logic               op1_ready,
	output logic               op2_ready,
	output ooo_pkg::reg_idx_t  rs1_idx,
	output ooo_pkg::reg_idx_t  rs2_idx
);

	import ooo_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_b5;
	logic       is_op;
	logic       is_imm;
	xlen_t      imm;
	xlen_t      rf [32];

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	assign opcode    = issue_inst[6:0];
	assign funct3    = issue_inst[14:12];
	assign funct7_b5 = issue_inst[30];
	assign is_op     = opcode == OPC_OP;
	assign is_imm    = opcode == OPC_OP_IMM;

	// I-type immediate, sign extended
	assign imm = {{20{issue_inst[31]}}, issue_inst[31:20]};

	// anything else turns into add x0, x0, x0
	assign dest_idx = (is_op || is_imm) ? issue_inst[11:7] : '0;
	assign rs1_idx  = (is_op || is_imm) ? issue_inst[19:15] : '0;
	// no rs2 for OP-IMM, so no false dependency
	assign rs2_idx  = is_op ? issue_inst[24:20] : '0;

	// x0 writes are dropped at commit
	assign has_dest = dest_idx != '0;

	always_comb begin
		unique case (funct3)
			3'b000: alu_op = (is_op && funct7_b5) ? ALU_SUB : ALU_ADD;
			3'b001: alu_op = ALU_SLL;
			3'b010: alu_op = ALU_SLT;
			3'b011: alu_op = ALU_SLTU;
			3'b100: alu_op = ALU_XOR;
			// srai carries the same bit 30 as sra
			3'b101: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
			3'b110: alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
		if (!(is_op || is_imm)) begin
			alu_op = ALU_ADD;
		end
	end

	////////////////////////////////////////
	// architectural register file
	////////////////////////////////////////

	// written only by in-order commit, x0 never written
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (commit_valid && commit_wr_en && commit_idx != '0) begin
			rf[commit_idx] <= commit_data;
		end
	end

	////////////////////////////////////////
	// operand select
	////////////////////////////////////////

	// regfile if not renamed, else finished ROB value, else wait on tag
	// a waiting operand carries its producer tag until the bus fills it
	always_comb begin
		if (!rs1_busy) begin
			op1       = rf[rs1_idx];
			op1_ready = 1'b1;
		end else if (rob_rs1_ready) begin
			op1       = rob_rs1_value;
			op1_ready = 1'b1;
		end else begin
			op1       = xlen_t'(rs1_tag);
			op1_ready = 1'b0;
		end
	end

	// immediate wins for OP-IMM
	always_comb begin
		if (is_imm) begin
			op2       = imm;
			op2_ready = 1'b1;
		end else if (!rs2_busy) begin
			op2       = rf[rs2_idx];
			op2_ready = 1'b1;
		end else if (rob_rs2_ready) begin
			op2       = rob_rs2_value;
			op2_ready = 1'b1;
		end else begin
			op2       = xlen_t'(rs2_tag);
			op2_ready = 1'b0;
		end
	end

endmodule

//--- src/map_table.sv
module map_table (
	input  logic               clock,
	input  logic               reset,
	input  ooo_pkg::reg_idx_t  rs1_idx,
	input  ooo_pkg::reg_idx_t  rs2_idx,
	input  logic               alloc_en,
	input  ooo_pkg::reg_idx_t  dest_idx,
	input  logic               has_dest,
	input  ooo_pkg::rob_tag_t  alloc_tag,
	input  logic               commit_valid,
	input  ooo_pkg::reg_idx_t  commit_idx,
	input  ooo_pkg::rob_tag_t  commit_tag,
	output logic               rs1_busy,
	output ooo_pkg::rob_tag_t  rs1_tag,
	output logic               rs2_busy,
	output ooo_pkg::rob_tag_t  rs2_tag
);

	import ooo_pkg::*;

	// one busy bit and youngest producer tag per register
	logic [31:0] busy;
	rob_tag_t    tag [32];

	// reads see the state before this cycle's rename
	assign rs1_busy = busy[rs1_idx];
	assign rs1_tag  = tag[rs1_idx];
	assign rs2_busy = busy[rs2_idx];
	assign rs2_tag  = tag[rs2_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			// clear only if no younger producer took the register
			if (commit_valid && tag[commit_idx] == commit_tag) begin
				busy[commit_idx] <= 1'b0;
			end
			// new rename wins over a same-cycle clear
			if (alloc_en && has_dest) begin
				busy[dest_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (alloc_en && has_dest) begin
			tag[dest_idx] <= alloc_tag;
		end
	end

endmodule

//--- rob/rob.sv
module rob (
	input  logic               clock,
	input  logic               reset,
	input  logic               alloc_en,
	input  ooo_pkg::reg_idx_t  dest_idx,
	input  logic               has_dest,
	input  logic               cdb_valid,
	input  ooo_pkg::rob_tag_t  cdb_tag,
	input  ooo_pkg::xlen_t     cdb_value,
	input  ooo_pkg::rob_tag_t  rs1_tag,
	input  ooo_pkg::rob_tag_t  rs2_tag,
	output logic               rob_full,
	output ooo_pkg::rob_tag_t  alloc_tag,
	output logic               rob_rs1_ready,
	output ooo_pkg::xlen_t     rob_rs1_value,
	output logic               rob_rs2_ready,
	output ooo_pkg::xlen_t     rob_rs2_value,
	output logic               commit_valid,
	output ooo_pkg::rob_tag_t  commit_tag,
	output logic               commit_wr_en,
	output ooo_pkg::reg_idx_t  commit_idx,
	output ooo_pkg::xlen_t     commit_data
);

	import ooo_pkg::*;

	// pointers and occupancy, count needs one extra bit
	rob_tag_t             head;
	rob_tag_t             tail;
	logic [ROB_TAG_W:0]   count;

	// per-entry state
	logic [ROB_DEPTH-1:0] done;
	logic [ROB_DEPTH-1:0] ent_has_dest;
	reg_idx_t             ent_idx [ROB_DEPTH];
	xlen_t                ent_value [ROB_DEPTH];

	logic                 rs1_bypass;
	logic                 rs2_bypass;

	////////////////////////////////////////
	// allocation side
	////////////////////////////////////////

	assign rob_full  = count == (ROB_TAG_W + 1)'(ROB_DEPTH);
	assign alloc_tag = tail;

	////////////////////////////////////////
	// operand read ports
	////////////////////////////////////////

	// same-cycle bus value counts as done
	assign rs1_bypass    = cdb_valid && cdb_tag == rs1_tag;
	assign rs2_bypass    = cdb_valid && cdb_tag == rs2_tag;
	assign rob_rs1_ready = done[rs1_tag] || rs1_bypass;
	assign rob_rs2_ready = done[rs2_tag] || rs2_bypass;
	assign rob_rs1_value = rs1_bypass ? cdb_value : ent_value[rs1_tag];
	assign rob_rs2_value = rs2_bypass ? cdb_value : ent_value[rs2_tag];

	////////////////////////////////////////
	// commit side
	////////////////////////////////////////

	// head retires once its result is in
	assign commit_valid = count != '0 && done[head];
	assign commit_tag   = head;
	assign commit_wr_en = ent_has_dest[head];
	assign commit_idx   = ent_idx[head];
	assign commit_data  = ent_value[head];

	// pointers and count
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (alloc_en) begin
				tail <= tail + 1'b1;
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			count <= count + (ROB_TAG_W + 1)'(alloc_en) - (ROB_TAG_W + 1)'(commit_valid);
		end
	end

	// entry fields, bus never targets the free tail slot
	always_ff @(posedge clock) begin
		if (alloc_en) begin
			done[tail]         <= 1'b0;
			ent_has_dest[tail] <= has_dest;
			ent_idx[tail]      <= dest_idx;
		end
		if (cdb_valid) begin
			done[cdb_tag]      <= 1'b1;
			ent_value[cdb_tag] <= cdb_value;
		end
	end

endmodule

//--- rs/reservation_station.sv
module reservation_station #(
	parameter int RS_DEPTH = 4
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               alloc_en,
	input  ooo_pkg::rob_tag_t  alloc_tag,
	input  ooo_pkg::alu_op_e   alu_op,
	input  ooo_pkg::xlen_t     op1,
	input  logic               op1_ready,
	input  ooo_pkg::rob_tag_t  rs1_tag,
	input  ooo_pkg::xlen_t     op2,
	input  logic               op2_ready,
	input  ooo_pkg::rob_tag_t  rs2_tag,
	input  logic               cdb_valid,
	input  ooo_pkg::rob_tag_t  cdb_tag,
	input  ooo_pkg::xlen_t     cdb_value,
	output logic               rs_full,
	output logic               ex_valid,
	output ooo_pkg::alu_op_e   ex_op,
	output ooo_pkg::xlen_t     ex_a,
	output ooo_pkg::xlen_t     ex_b,
	output ooo_pkg::rob_tag_t  ex_tag
);

	import ooo_pkg::*;

	// slot index width, at least one bit
	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	logic [RS_DEPTH-1:0] ent_valid;
	alu_op_e             ent_op [RS_DEPTH];
	rob_tag_t            ent_tag [RS_DEPTH];
	xlen_t               a_val [RS_DEPTH];
	xlen_t               b_val [RS_DEPTH];
	rob_tag_t            a_tag [RS_DEPTH];
	rob_tag_t            b_tag [RS_DEPTH];
	logic [RS_DEPTH-1:0] a_rdy;
	logic [RS_DEPTH-1:0] b_rdy;

	logic                free_found;
	logic [IDX_W-1:0]    free_idx;
	logic [IDX_W-1:0]    pick;
	rob_tag_t            age;
	rob_tag_t            best_age;
	logic                a_hit;
	logic                b_hit;

	////////////////////////////////////////
	// free slot search
	////////////////////////////////////////

	// lowest empty slot
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (!ent_valid[i] && !free_found) begin
				free_found = 1'b1;
				free_idx   = IDX_W'(i);
			end
		end
	end

	assign rs_full = !free_found;

	////////////////////////////////////////
	// oldest-ready select
	////////////////////////////////////////

	// age relative to the ROB tail, smaller is older, holds when full too
	always_comb begin
		ex_valid = 1'b0;
		pick     = '0;
		best_age = '1;
		age      = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			age = ent_tag[i] - alloc_tag;
			if (ent_valid[i] && a_rdy[i] && b_rdy[i] && (!ex_valid || age < best_age)) begin
				ex_valid = 1'b1;
				pick     = IDX_W'(i);
				best_age = age;
			end
		end
	end

	assign ex_op  = ent_op[pick];
	assign ex_a   = a_val[pick];
	assign ex_b   = b_val[pick];
	assign ex_tag = ent_tag[pick];

	// occupancy, dispatch frees and alloc fills different slots
	always_ff @(posedge clock) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			if (ex_valid) begin
				ent_valid[pick] <= 1'b0;
			end
			if (alloc_en) begin
				ent_valid[free_idx] <= 1'b1;
			end
		end
	end

	// bus result landing in the cycle of allocation
	assign a_hit = cdb_valid && !op1_ready && cdb_tag == rs1_tag;
	assign b_hit = cdb_valid && !op2_ready && cdb_tag == rs2_tag;

	// operand capture and new entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
				a_val[i] <= cdb_value;
				a_rdy[i] <= 1'b1;
			end
			if (cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
				b_val[i] <= cdb_value;
				b_rdy[i] <= 1'b1;
			end
		end
		if (alloc_en) begin
			ent_op[free_idx]  <= alu_op;
			ent_tag[free_idx] <= alloc_tag;
			a_tag[free_idx]   <= rs1_tag;
			b_tag[free_idx]   <= rs2_tag;
			a_val[free_idx]   <= a_hit ? cdb_value : op1;
			b_val[free_idx]   <= b_hit ? cdb_value : op2;
			a_rdy[free_idx]   <= op1_ready || a_hit;
			b_rdy[free_idx]   <= op2_ready || b_hit;
		end
	end

endmodule

//--- src/alu_unit.sv
module alu_unit (
	input  logic               clock,
	input  logic               reset,
	input  logic               ex_valid,
	input  ooo_pkg::alu_op_e   ex_op,
	input  ooo_pkg::xlen_t     ex_a,
	input  ooo_pkg::xlen_t     ex_b,
	input  ooo_pkg::rob_tag_t  ex_tag,
	output logic               cdb_valid,
	output ooo_pkg::rob_tag_t  cdb_tag,
	output ooo_pkg::xlen_t     cdb_value
);

	import ooo_pkg::*;

	xlen_t    result;
	// shifts take the low five bits only
	logic [4:0] shamt;

	assign shamt = ex_b[4:0];

	always_comb begin
		unique case (ex_op)
			ALU_SUB:  result = ex_a - ex_b;
			ALU_SLL:  result = ex_a << shamt;
			ALU_SLT:  result = xlen_t'($signed(ex_a) < $signed(ex_b));
			ALU_SLTU: result = xlen_t'(ex_a < ex_b);
			ALU_XOR:  result = ex_a ^ ex_b;
			ALU_SRL:  result = ex_a >> shamt;
			ALU_SRA:  result = $signed(ex_a) >>> shamt;
			ALU_OR:   result = ex_a | ex_b;
			ALU_AND:  result = ex_a & ex_b;
			default:  result = ex_a + ex_b;
		endcase
	end

	// bus register, one pulse per dispatch
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clock) begin
		cdb_tag   <= ex_tag;
		cdb_value <= result;
	end

endmodule

//--- src/ooo_core.sv
module ooo_core #(
	parameter int RS_DEPTH = 4
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               inst_valid,
	input  ooo_pkg::inst_t     inst,
	output logic               issue_stall,
	output logic               commit_valid,
	output logic               commit_wr_en,
	output ooo_pkg::reg_idx_t  commit_idx,
	output ooo_pkg::xlen_t     commit_data
);

	import ooo_pkg::*;

	// issue control
	logic      alloc_en;
	inst_t     issue_inst;
	logic      rob_full;
	logic      rs_full;

	// rename lookups
	reg_idx_t  rs1_idx;
	reg_idx_t  rs2_idx;
	logic      rs1_busy;
	logic      rs2_busy;
	rob_tag_t  rs1_tag;
	rob_tag_t  rs2_tag;

	// decoded instruction
	reg_idx_t  dest_idx;
	logic      has_dest;
	alu_op_e   alu_op;
	xlen_t     op1;
	xlen_t     op2;
	logic      op1_ready;
	logic      op2_ready;

	// ROB reads and commit
	rob_tag_t  alloc_tag;
	logic      rob_rs1_ready;
	logic      rob_rs2_ready;
	xlen_t     rob_rs1_value;
	xlen_t     rob_rs2_value;
	rob_tag_t  commit_tag;

	// dispatch and bus
	logic      ex_valid;
	alu_op_e   ex_op;
	xlen_t     ex_a;
	xlen_t     ex_b;
	rob_tag_t  ex_tag;
	logic      cdb_valid;
	rob_tag_t  cdb_tag;
	xlen_t     cdb_value;

	////////////////////////////////////////
	// front end
	////////////////////////////////////////

	issue_control issue_control_i (
		.clock       (clock),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.rob_full    (rob_full),
		.rs_full     (rs_full),
		.issue_stall (issue_stall),
		.alloc_en    (alloc_en),
		.issue_inst  (issue_inst)
	);

	issue_stage issue_stage_i (
		.clock         (clock),
		.reset         (reset),
		.issue_inst    (issue_inst),
		.commit_valid  (commit_valid),
		.commit_wr_en  (commit_wr_en),
		.commit_idx    (commit_idx),
		.commit_data   (commit_data),
		.rs1_busy      (rs1_busy),
		.rs1_tag       (rs1_tag),
		.rs2_busy      (rs2_busy),
		.rs2_tag       (rs2_tag),
		.rob_rs1_ready (rob_rs1_ready),
		.rob_rs1_value (rob_rs1_value),
		.rob_rs2_ready (rob_rs2_ready),
		.rob_rs2_value (rob_rs2_value),
		.dest_idx      (dest_idx),
		.has_dest      (has_dest),
		.alu_op        (alu_op),
		.op1           (op1),
		.op2           (op2),
		.op1_ready     (op1_ready),
		.op2_ready     (op2_ready),
		.rs1_idx       (rs1_idx),
		.rs2_idx       (rs2_idx)
	);

	map_table map_table_i (
		.clock        (clock),
		.reset        (reset),
		.rs1_idx      (rs1_idx),
		.rs2_idx      (rs2_idx),
		.alloc_en     (alloc_en),
		.dest_idx     (dest_idx),
		.has_dest     (has_dest),
		.alloc_tag    (alloc_tag),
		.commit_valid (commit_valid),
		.commit_idx   (commit_idx),
		.commit_tag   (commit_tag),
		.rs1_busy     (rs1_busy),
		.rs1_tag      (rs1_tag),
		.rs2_busy     (rs2_busy),
		.rs2_tag      (rs2_tag)
	);

	////////////////////////////////////////
	// back end
	////////////////////////////////////////

	rob rob_i (
		.clock         (clock),
		.reset         (reset),
		.alloc_en      (alloc_en),
		.dest_idx      (dest_idx),
		.has_dest      (has_dest),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.rs1_tag       (rs1_tag),
		.rs2_tag       (rs2_tag),
		.rob_full      (rob_full),
		.alloc_tag     (alloc_tag),
		.rob_rs1_ready (rob_rs1_ready),
		.rob_rs1_value (rob_rs1_value),
		.rob_rs2_ready (rob_rs2_ready),
		.rob_rs2_value (rob_rs2_value),
		.commit_valid  (commit_valid),
		.commit_tag    (commit_tag),
		.commit_wr_en  (commit_wr_en),
		.commit_idx    (commit_idx),
		.commit_data   (commit_data)
	);

	reservation_station #(
		.RS_DEPTH (RS_DEPTH)
	) reservation_station_i (
		.clock     (clock),
		.reset     (reset),
		.alloc_en  (alloc_en),
		.alloc_tag (alloc_tag),
		.alu_op    (alu_op),
		.op1       (op1),
		.op1_ready (op1_ready),
		.rs1_tag   (rs1_tag),
		.op2       (op2),
		.op2_ready (op2_ready),
		.rs2_tag   (rs2_tag),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_value (cdb_value),
		.rs_full   (rs_full),
		.ex_valid  (ex_valid),
		.ex_op     (ex_op),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_tag    (ex_tag)
	);

	// single unit, so its output register is the bus
	alu_unit alu_unit_i (
		.clock     (clock),
		.reset     (reset),
		.ex_valid  (ex_valid),
		.ex_op     (ex_op),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_tag    (ex_tag),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_value (cdb_value)
	);

endmodule

//--- test/tb_ooo_core.sv
module tb_ooo_core;

	timeunit 1ns;
	timeprecision 100ps;

	import ooo_pkg::*;

	logic     clock;
	logic     reset;
	logic     inst_valid;
	inst_t    inst;
	logic     issue_stall;
	logic     commit_valid;
	logic     commit_wr_en;
	reg_idx_t commit_idx;
	xlen_t    commit_data;

	int       seed = 11191;
	int       error_count = 0;
	int       accepted_count = 0;
	int       commit_count = 0;
	logic     stall_seen = 1'b0;
	string    test_name = "reset";

	// reference register file, x0 never written
	xlen_t    model_rf [32];

	// expected commits in acceptance order
	reg_idx_t exp_idx_q [$];
	logic     exp_wr_q [$];
	xlen_t    exp_data_q [$];

	ooo_core #(
		.RS_DEPTH (4)
	) ooo_core_i (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.issue_stall  (issue_stall),
		.commit_valid (commit_valid),
		.commit_wr_en (commit_wr_en),
		.commit_idx   (commit_idx),
		.commit_data  (commit_data)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_data(string what, xlen_t expected, xlen_t actual);
		if (expected !== actual) begin
			$display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_idx(string what, reg_idx_t expected, reg_idx_t actual);
		if (expected !== actual) begin
			$display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(string what, logic expected, logic actual);
		if (expected !== actual) begin
			$display("mismatch %s %s: expected %b actual %b", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// RV32I OP / OP-IMM result from the model register file
	function automatic xlen_t model_result(inst_t i);
		xlen_t a;
		xlen_t b;
		logic  is_imm;
		is_imm = i[6:0] == OPC_OP_IMM;
		a = model_rf[i[19:15]];
		b = is_imm ? {{20{i[31]}}, i[31:20]} : model_rf[i[24:20]];
		case (i[14:12])
			3'b000: return (!is_imm && i[30]) ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			// arithmetic shift when bit 30 set, srai too
			3'b101: return i[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// expected commit pushed at the accepting edge
	task automatic record_accept(inst_t i);
		xlen_t    res;
		reg_idx_t rd;
		rd = i[11:7];
		res = model_result(i);
		exp_idx_q.push_back(rd);
		exp_wr_q.push_back(rd != 5'd0);
		exp_data_q.push_back(res);
		if (rd != 5'd0) begin
			model_rf[rd] = res;
		end
		accepted_count++;
	endtask

	////////////////////////////////////////
	// instruction building
	////////////////////////////////////////

	function automatic inst_t r_type_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_t i_type_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic int pick_below(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// x0..x4 only, so dependencies are frequent
	function automatic reg_idx_t any_reg();
		return reg_idx_t'(pick_below(5));
	endfunction

	// one of the ten register forms or nine immediate forms
	function automatic inst_t mixed_inst(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		int          r;
		logic [11:0] imm;
		r = $random(seed);
		imm = r[11:0];
		case (pick_below(19))
			0: return r_type_word(7'h00, rs2, rs1, 3'b000, rd);
			1: return r_type_word(7'h20, rs2, rs1, 3'b000, rd);
			2: return r_type_word(7'h00, rs2, rs1, 3'b001, rd);
			3: return r_type_word(7'h00, rs2, rs1, 3'b010, rd);
			4: return r_type_word(7'h00, rs2, rs1, 3'b011, rd);
			5: return r_type_word(7'h00, rs2, rs1, 3'b100, rd);
			6: return r_type_word(7'h00, rs2, rs1, 3'b101, rd);
			7: return r_type_word(7'h20, rs2, rs1, 3'b101, rd);
			8: return r_type_word(7'h00, rs2, rs1, 3'b110, rd);
			9: return r_type_word(7'h00, rs2, rs1, 3'b111, rd);
			10: return i_type_word(imm, rs1, 3'b000, rd);
			11: return i_type_word({7'h00, imm[4:0]}, rs1, 3'b001, rd);
			12: return i_type_word(imm, rs1, 3'b010, rd);
			13: return i_type_word(imm, rs1, 3'b011, rd);
			14: return i_type_word(imm, rs1, 3'b100, rd);
			15: return i_type_word({7'h00, imm[4:0]}, rs1, 3'b101, rd);
			16: return i_type_word({7'h20, imm[4:0]}, rs1, 3'b101, rd);
			17: return i_type_word(imm, rs1, 3'b110, rd);
			default: return i_type_word(imm, rs1, 3'b111, rd);
		endcase
	endfunction

	////////////////////////////////////////
	// drive and wait
	////////////////////////////////////////

	// hold the word until a negedge shows no stall, taken at the next edge
	task automatic send_inst(inst_t i);
		int waited;
		@(posedge clock);
		#2;
		inst_valid = 1'b1;
		inst = i;
		waited = 0;
		@(negedge clock);
		while (issue_stall && waited < 200) begin
			stall_seen = 1'b1;
			waited++;
			@(negedge clock);
		end
		if (issue_stall) begin
			$display("error %s: instruction not accepted within 200 cycles", test_name);
			error_count++;
		end else begin
			record_accept(i);
		end
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clock);
			#2;
			inst_valid = 1'b0;
		end
	endtask

	// timeout restarts whenever a commit arrives
	task automatic wait_drained();
		int waited;
		int last_size;
		@(posedge clock);
		#2;
		inst_valid = 1'b0;
		waited = 0;
		last_size = exp_idx_q.size();
		while (exp_idx_q.size() != 0 && waited < 200) begin
			if (exp_idx_q.size() < last_size) begin
				waited = 0;
			end
			last_size = exp_idx_q.size();
			waited++;
			@(posedge clock);
		end
		if (exp_idx_q.size() != 0) begin
			$display("error %s: %0d commits still missing after 200 idle cycles",
				test_name, exp_idx_q.size());
			error_count++;
		end
	endtask

	// commit monitor, outputs stable at the falling edge
	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			commit_count++;
			if (exp_idx_q.size() == 0) begin
				$display("error %s: commit with no instruction outstanding", test_name);
				error_count++;
			end else begin
				check_idx("commit_idx", exp_idx_q.pop_front(), commit_idx);
				check_flag("commit_wr_en", exp_wr_q.pop_front(), commit_wr_en);
				check_data("commit_data", exp_data_q.pop_front(), commit_data);
			end
		end
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	// idle outputs, then reads of registers nobody wrote
	task automatic after_reset_reads();
		test_name = "after_reset_reads";
		@(negedge clock);
		check_flag("issue_stall", 1'b0, issue_stall);
		check_flag("commit_valid", 1'b0, commit_valid);
		send_inst(r_type_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd1));
		send_inst(r_type_word(7'h20, 5'd6, 5'd5, 3'b000, 5'd4));
		send_inst(i_type_word(12'h000, 5'd8, 3'b100, 5'd7));
		send_inst(r_type_word(7'h00, 5'd11, 5'd10, 3'b011, 5'd9));
		wait_drained();
	endtask

	task automatic random_mix();
		test_name = "random_mix";
		for (int n = 0; n < 200; n++) begin
			send_inst(mixed_inst(any_reg(), any_reg(), any_reg()));
			if (pick_below(4) == 0) begin
				idle_cycles(pick_below(3) + 1);
			end
		end
		wait_drained();
	endtask

	// each rs1 is the previous destination, gaps move the value to the ROB
	task automatic dependent_chains();
		reg_idx_t prev;
		reg_idx_t rd;
		test_name = "dependent_chains";
		prev = 5'd1;
		for (int n = 0; n < 60; n++) begin
			rd = reg_idx_t'(pick_below(4) + 1);
			send_inst(mixed_inst(rd, prev, any_reg()));
			prev = rd;
			if (pick_below(3) == 0) begin
				idle_cycles(pick_below(3) + 1);
			end
		end
		wait_drained();
	endtask

	// chain dispatches every other cycle, so the station fills
	task automatic full_queue_burst();
		int       acc_before;
		int       com_before;
		reg_idx_t prev;
		reg_idx_t rd;
		test_name = "full_queue_burst";
		stall_seen = 1'b0;
		acc_before = accepted_count;
		com_before = commit_count;
		prev = 5'd2;
		for (int n = 0; n < 40; n++) begin
			rd = reg_idx_t'(pick_below(4) + 1);
			send_inst(mixed_inst(rd, prev, prev));
			prev = rd;
		end
		wait_drained();
		idle_cycles(4);
		check_flag("issue_stall raised", 1'b1, stall_seen);
		if (commit_count - com_before != accepted_count - acc_before) begin
			$display("mismatch %s commit count: expected %0d actual %0d", test_name,
				accepted_count - acc_before, commit_count - com_before);
			error_count++;
		end
	endtask

	task automatic zero_register_dest();
		test_name = "zero_register_dest";
		// addi x0, x1, 123 and add x0, x2, x0
		send_inst(i_type_word(12'h07b, 5'd1, 3'b000, 5'd0));
		send_inst(r_type_word(7'h00, 5'd0, 5'd2, 3'b000, 5'd0));
		// reads of x0 after the dropped writes
		send_inst(r_type_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd3));
		send_inst(i_type_word(12'h000, 5'd0, 3'b000, 5'd4));
		send_inst(r_type_word(7'h00, 5'd0, 5'd4, 3'b000, 5'd1));
		wait_drained();
	endtask

	initial begin
		for (int r = 0; r < 32; r++) begin
			model_rf[r] = '0;
		end
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		after_reset_reads();
		random_mix();
		dependent_chains();
		full_queue_burst();
		zero_register_dest();
		$display("summary: %0d accepted, %0d committed, %0d errors",
			accepted_count, commit_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- project.f
common/ooo_pkg.sv
src/issue_control.sv
src/issue_stage.sv
src/map_table.sv
rob/rob.sv
rs/reservation_station.sv
src/alu_unit.sv
src/ooo_core.sv
test/tb_ooo_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_ooo_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
